//--- build.f
common/mem_pkg.sv
ram/byte_ram.sv
verilog/access_sequencer.sv
verilog/load_unit.sv
verilog/mem_subsystem.sv
sim/clock_gen.sv
sim/mem_subsystem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the memory subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module mem_subsystem_tb \
    -f build.f \
    --Mdir obj_dir \
    -o mem_subsystem_sim

./obj_dir/mem_subsystem_sim | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"

//--- sim/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;

    import mem_pkg::*;

    localparam int NUM_CMDS       = 400;
    localparam int DONE_SLOT      = 3;              // Falling edge that follows E2.
    localparam int BUSY_SLOTS     = BUSY_CYCLES + 2;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * (BUSY_CYCLES + 4) + 100;

    logic  clk;
    logic  rst_n;
    logic  cmd_strobe;
    logic  cmd_write;
    size_t cmd_size;
    logic  cmd_unsigned;
    addr_t cmd_addr;
    word_t cmd_wdata;
    logic  busy;
    logic  load_done;
    word_t load_data;

    lane_t model_mem [0:(2**ADDR_BITS)-1];          // Expected memory contents.
    logic  written   [0:(2**ADDR_BITS)-1];          // Set once a byte has been stored.
    int    data_errors = 0;
    int    flag_errors = 0;
    int    cycle_count = 0;

    clock_gen clk0 (.clk(clk), .rst_n(rst_n));

    mem_subsystem dut0 (
        .clk(clk), .rst_n(rst_n),
        .cmd_strobe(cmd_strobe), .cmd_write(cmd_write), .cmd_size(cmd_size),
        .cmd_unsigned(cmd_unsigned), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
        .busy(busy), .load_done(load_done), .load_data(load_data)
    );

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic int lane_count(input size_t size);
        case (size)
            SIZE_BYTE: lane_count = 1;
            SIZE_HALF: lane_count = 2;
            default:   lane_count = LANES;
        endcase
    endfunction

    function automatic logic bytes_written(input addr_t addr, input size_t size);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < lane_count(size); i++) begin
            if (!written[addr + addr_t'(i)]) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic word_t expected_load(input addr_t addr, input size_t size,
                                            input logic uns);
        word_t raw;
        int    n;
        raw = '0;
        n   = lane_count(size);
        for (int i = 0; i < n; i++) begin
            raw[i*LANE_BITS +: LANE_BITS] = model_mem[addr + addr_t'(i)];
        end
        // The top loaded bit fills the upper lanes of a signed load.
        if (n < LANES && !uns && raw[n*LANE_BITS-1]) begin
            raw = raw | ~((word_t'(1) << (n * LANE_BITS)) - word_t'(1));
        end
        return raw;
    endfunction

    task automatic store_model(input addr_t addr, input size_t size, input word_t wdata);
        for (int i = 0; i < lane_count(size); i++) begin
            model_mem[addr + addr_t'(i)] = wdata[i*LANE_BITS +: LANE_BITS];
            written[addr + addr_t'(i)]   = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            data_errors++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            flag_errors++;
            $display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // Issues one command and follows it until busy drops. A nonzero
    // drop_slot repeats a store strobe while the DUT is still busy.
    task automatic run_command(input logic write, input size_t size, input logic uns,
                               input addr_t addr, input word_t wdata, input int drop_slot);
        int    k;
        word_t expected;
        expected     = expected_load(addr, size, uns);
        cmd_strobe   = 1'b1;
        cmd_write    = write;
        cmd_size     = size;
        cmd_unsigned = uns;
        cmd_addr     = addr;
        cmd_wdata    = wdata;
        if (write) begin
            store_model(addr, size, wdata);
        end
        k = 0;
        do begin
            @(negedge clk);
            k++;
            compare_flag("busy", k <= BUSY_SLOTS, busy);
            compare_flag("load_done", !write && k == DONE_SLOT, load_done);
            if (!write && k == DONE_SLOT) begin
                compare_word("load_data", expected, load_data);
            end
            cmd_strobe = 1'b0;
            if (k == drop_slot) begin
                cmd_strobe = 1'b1;                  // Must be ignored, so the model stays.
                cmd_write  = 1'b1;
                cmd_wdata  = ~expected_load(addr, size, 1'b1);
            end
        end while (busy);
        cmd_strobe = 1'b0;
    endtask

    // Hard limit on the run length.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin : stimulus
        logic  write;
        size_t size;
        logic  uns;
        addr_t addr;
        word_t wdata;
        int    drop_slot;
        logic  follow_up;
        void'($urandom(8));
        cmd_strobe   = 1'b0;
        cmd_write    = 1'b0;
        cmd_size     = SIZE_BYTE;
        cmd_unsigned = 1'b0;
        cmd_addr     = '0;
        cmd_wdata    = '0;
        follow_up    = 1'b0;
        addr         = '0;
        size         = SIZE_BYTE;
        for (int i = 0; i < 2**ADDR_BITS; i++) begin
            model_mem[i] = '0;
            written[i]   = 1'b0;
        end
        @(posedge rst_n);
        repeat (5) begin
            @(negedge clk);
            compare_flag("busy", 1'b0, busy);       // Quiet until the first strobe.
            compare_flag("load_done", 1'b0, load_done);
        end
        for (int n = 0; n < NUM_CMDS; n++) begin
            uns   = ($urandom % 2) == 1;
            wdata = word_t'($urandom);
            if (follow_up) begin
                write = 1'b0;                       // Reads back the bytes of the dropped store.
            end else begin
                write = ($urandom % 2) == 1;
                size  = size_t'($urandom % 3);
                if ($urandom % 8 == 0) begin
                    addr = addr_t'(253 + $urandom % 3);
                end else begin
                    addr = addr_t'($urandom);
                end
            end
            if (!write && !bytes_written(addr, size)) begin
                write = 1'b1;
            end
            drop_slot = 0;
            if ($urandom % 4 == 0) begin
                drop_slot = 1 + int'($urandom % (BUSY_CYCLES + 1));
            end
            run_command(write, size, uns, addr, wdata, drop_slot);
            follow_up = (drop_slot != 0);
        end
        $display("checks done: %0d data errors, %0d flag errors", data_errors, flag_errors);
        if (data_errors + flag_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                       // 8 ns period.
    end

    // Reset covers four rising edges and is released on a falling edge.
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- verilog/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_strobe,
    input  logic                cmd_write,
    input  mem_pkg::size_t      cmd_size,
    input  logic                cmd_unsigned,
    input  mem_pkg::addr_t      cmd_addr,
    input  mem_pkg::word_t      cmd_wdata,
    output logic                busy,
    output logic                load_done,
    output mem_pkg::word_t      load_data
);

    import mem_pkg::*;

    // ------------------------------------------------------------
    // Sequencer to RAM and load unit
    // ------------------------------------------------------------
    logic     chip_select;
    logic     write_enable;
    logic     output_enable;
    byte_en_t byte_enable;
    addr_t    address;
    word_t    write_data;
    logic     load_strobe;
    size_t    load_size;
    logic     load_unsigned;
    word_t    read_data;                             // RAM read register to load unit.
    logic     ram_busy;

    access_sequencer seq0 (
        .clk(clk), .rst_n(rst_n),
        .cmd_strobe(cmd_strobe), .cmd_write(cmd_write), .cmd_size(cmd_size),
        .cmd_unsigned(cmd_unsigned), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
        .ram_busy(ram_busy),
        .chip_select(chip_select), .write_enable(write_enable),
        .output_enable(output_enable), .byte_enable(byte_enable),
        .address(address), .write_data(write_data),
        .load_strobe(load_strobe), .load_size(load_size),
        .load_unsigned(load_unsigned), .busy(busy)
    );

    byte_ram ram0 (
        .clk(clk), .rst_n(rst_n),
        .address(address), .write_data(write_data),
        .output_enable(output_enable), .write_enable(write_enable),
        .chip_select(chip_select), .byte_enable(byte_enable),
        .read_data(read_data), .ram_busy(ram_busy)
    );

    load_unit load0 (
        .clk(clk), .rst_n(rst_n),
        .load_strobe(load_strobe), .load_size(load_size),
        .load_unsigned(load_unsigned), .read_data(read_data),
        .load_done(load_done), .load_data(load_data)
    );

endmodule

//--- verilog/load_unit.sv
`timescale 1ns/1ps

module load_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_strobe,
    input  mem_pkg::size_t      load_size,
    input  logic                load_unsigned,
    input  mem_pkg::word_t      read_data,
    output logic                load_done,
    output mem_pkg::word_t      load_data
);

    import mem_pkg::*;

    logic   pend_strobe;                             // Load strobe lined up with read_data.
    size_t  pend_size;
    logic   pend_unsigned;
    word_t  aligned;                                 // Extended result before the register.

    // ------------------------------------------------------------
    // Stage 1 waits for the RAM read register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_strobe <= 1'b0;
        end else begin
            pend_strobe <= load_strobe;
        end
    end

    always_ff @(posedge clk) begin
        pend_size     <= load_size;
        pend_unsigned <= load_unsigned;
    end

    // Sign or zero extension of the low byte or half.
    always_comb begin
        case (pend_size)
            SIZE_BYTE: aligned = pend_unsigned
                ? word_t'(read_data[LANE_BITS-1:0])
                : word_t'($signed(read_data[LANE_BITS-1:0]));
            SIZE_HALF: aligned = pend_unsigned
                ? word_t'(read_data[2*LANE_BITS-1:0])
                : word_t'($signed(read_data[2*LANE_BITS-1:0]));
            default:   aligned = read_data;          // Words pass straight through.
        endcase
    end

    // ------------------------------------------------------------
    // Stage 2 holds the result register and the done pulse
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_done <= 1'b0;
        end else begin
            load_done <= pend_strobe;                // One cycle per load.
        end
    end

    always_ff @(posedge clk) begin
        if (pend_strobe) begin
            load_data <= aligned;
        end
    end

endmodule

//--- verilog/access_sequencer.sv
`timescale 1ns/1ps

module access_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_strobe,
    input  logic                cmd_write,
    input  mem_pkg::size_t      cmd_size,
    input  logic                cmd_unsigned,
    input  mem_pkg::addr_t      cmd_addr,
    input  mem_pkg::word_t      cmd_wdata,
    input  logic                ram_busy,
    output logic                chip_select,
    output logic                write_enable,
    output logic                output_enable,
    output mem_pkg::byte_en_t   byte_enable,
    output mem_pkg::addr_t      address,
    output mem_pkg::word_t      write_data,
    output logic                load_strobe,
    output mem_pkg::size_t      load_size,
    output logic                load_unsigned,
    output logic                busy
);

    import mem_pkg::*;

    seq_state_t state;
    logic       accept;                              // A command is taken at this edge.

    // Byte enables for an access that starts at lane 0.
    function automatic byte_en_t size_to_lanes(input size_t size);
        case (size)
            SIZE_BYTE: size_to_lanes = byte_en_t'(4'b0001);
            SIZE_HALF: size_to_lanes = byte_en_t'(4'b0011);
            default:   size_to_lanes = '1;           // SIZE_WORD and the spare code.
        endcase
    endfunction

    assign accept = (state == IDLE) && cmd_strobe;   // Strobes in other states are dropped.
    assign busy   = (state != IDLE);

    // ------------------------------------------------------------
    // Control FSM and access strobes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= IDLE;
            chip_select   <= 1'b0;
            write_enable  <= 1'b0;
            output_enable <= 1'b0;
            byte_enable   <= '0;
            load_strobe   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state         <= ACCESS;
                        chip_select   <= 1'b1;
                        write_enable  <= cmd_write;
                        output_enable <= !cmd_write;
                        byte_enable   <= size_to_lanes(cmd_size);
                        load_strobe   <= !cmd_write; // Only loads produce a result.
                    end
                end
                ACCESS: begin
                    state         <= WAIT;           // Strobes last exactly one cycle.
                    chip_select   <= 1'b0;
                    write_enable  <= 1'b0;
                    output_enable <= 1'b0;
                    byte_enable   <= '0;
                    load_strobe   <= 1'b0;
                end
                WAIT: begin
                    if (!ram_busy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // The command payload is captured with the accepting edge.
    always_ff @(posedge clk) begin
        if (accept) begin
            address       <= cmd_addr;
            write_data    <= cmd_wdata;
            load_size     <= cmd_size;
            load_unsigned <= cmd_unsigned;
        end
    end

endmodule

//--- ram/byte_ram.sv
`timescale 1ns/1ps

module byte_ram (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::addr_t      address,
    input  mem_pkg::word_t      write_data,
    input  logic                output_enable,
    input  logic                write_enable,
    input  logic                chip_select,
    input  mem_pkg::byte_en_t   byte_enable,
    output mem_pkg::word_t      read_data,
    output logic                ram_busy
);

    import mem_pkg::*;

    lane_t     mem [0:(2**ADDR_BITS)-1];             // Byte storage without initial contents.
    busy_cnt_t busy_cnt;                             // Cycles of busy left.
    logic      do_write;
    logic      do_read;

    // Lane i of a word lives at base + i, wrapping inside the RAM.
    function automatic addr_t lane_addr(input addr_t base, input int lane);
        lane_addr = base + addr_t'(lane);
    endfunction

    assign do_write = chip_select && write_enable;   // Store strobe for this cycle.
    assign do_read  = chip_select && output_enable;  // Load strobe for this cycle.

    // ------------------------------------------------------------
    // Storage write port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (do_write && byte_enable[i]) begin
                mem[lane_addr(address, i)] <= write_data[i*LANE_BITS +: LANE_BITS];
            end
        end
    end

    // ------------------------------------------------------------
    // Registered read port
    // ------------------------------------------------------------
    // Disabled lanes come back as zero so that the load unit only
    // sees the bytes it asked for.
    always_ff @(posedge clk) begin
        if (do_read) begin
            for (int j = 0; j < LANES; j++) begin
                if (byte_enable[j]) begin
                    read_data[j*LANE_BITS +: LANE_BITS] <= mem[lane_addr(address, j)];
                end else begin
                    read_data[j*LANE_BITS +: LANE_BITS] <= '0;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Busy counter
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (do_write || do_read) begin
            busy_cnt <= busy_cnt_t'(BUSY_CYCLES);    // Every access restarts the count.
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign ram_busy = (busy_cnt != '0);              // High for BUSY_CYCLES after an access.

endmodule

//--- common/mem_pkg.sv
package mem_pkg;

    // ------------------------------------------------------------
    // Geometry of the byte-addressed data memory
    // ------------------------------------------------------------
    localparam int ADDR_BITS   = 8;                   // 256 bytes of storage.
    localparam int LANE_BITS   = 8;                   // One byte per lane.
    localparam int LANES       = 4;                   // Four lanes make a word.
    localparam int BUSY_CYCLES = 3;                   // RAM busy time after an access.

    typedef logic [ADDR_BITS-1:0]         addr_t;     // Byte address.
    typedef logic [LANES*LANE_BITS-1:0]   word_t;     // Full data word.
    typedef logic [LANE_BITS-1:0]         lane_t;     // One byte lane.
    typedef logic [LANES-1:0]             byte_en_t;  // One enable per lane.
    typedef logic [1:0]                   size_t;     // Access size code.
    typedef logic [1:0]                   busy_cnt_t; // Holds up to BUSY_CYCLES.

    // ------------------------------------------------------------
    // Access size codes
    // ------------------------------------------------------------
    // Lane 0 always carries the byte at the base address, so a half
    // uses lanes 0 and 1 and a word uses every lane.
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // ------------------------------------------------------------
    // Sequencer states
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE   = 2'd0,                                // Ready for a command.
        ACCESS = 2'd1,                                // Strobes are out to the RAM.
        WAIT   = 2'd2                                 // Waiting for the RAM to go idle.
    } seq_state_t;

endpackage
